// File: verilog/mci_defines.svh
////////////////////
// Width macros for the management controller error block
//   Watchdog counter and period width
//   Firmware error code width
//   Count of external aggregate error sources
////////////////////

`ifndef MCI_DEFINES_SVH
`define MCI_DEFINES_SVH

////////////////////
// Watchdog
////////////////////

// Both timers share one counter width
`define MCI_WDT_CNT_W 16

////////////////////
// Error sources
////////////////////

// Firmware writes a full word as its error code
`define MCI_FW_ERR_W 32

// External aggregate inputs, one per source, fatal and non-fatal alike
`define MCI_AGG_ERR_W 8

`endif

// File: verilog/mci_pkg.sv
////////////////////
// Shared types for the management controller error block
//   Vector typedefs for counts, codes and aggregate sources
//   Watchdog configuration, control and status structs
//   Hardware error vectors, fatal and non-fatal
////////////////////

`include "mci_defines.svh"

`default_nettype none

package mci_pkg;

  // Plain vectors with a meaning of their own
  typedef logic [`MCI_WDT_CNT_W-1:0] wdt_cnt_t;
  typedef logic [`MCI_FW_ERR_W-1:0]  fw_err_t;
  typedef logic [`MCI_AGG_ERR_W-1:0] agg_err_t;

  ////////////////////
  // Watchdog
  ////////////////////

  // t2_en high selects independent mode, low selects cascade
  typedef struct packed {
    logic     t1_en;
    logic     t2_en;
    wdt_cnt_t t1_period;
    wdt_cnt_t t2_period;
  } wdt_cfg_t;

  // One-cycle strobes
  typedef struct packed {
    logic t1_restart;
    logic t2_restart;
    logic t1_service;
    logic t2_service;
  } wdt_ctrl_t;

  typedef struct packed {
    logic t1_timeout;
    logic t2_timeout;
  } wdt_status_t;

  ////////////////////
  // Hardware errors
  ////////////////////

  // Same layout for the sticky bits, their masks and their clears
  typedef struct packed {
    logic nmi;
    logic sram_ecc_unc;
    logic dmi_axi_collision;
  } hw_err_fatal_t;

  typedef struct packed {
    logic mbox0_ecc_unc;
    logic mbox1_ecc_unc;
  } hw_err_non_fatal_t;

endpackage

`default_nettype wire

// File: verilog/mci_wdt.sv
////////////////////
// Two-timer watchdog
//   Cascade mode: timer 2 runs only while timer 1 has expired
//   Independent mode: both timers run on their own
//   Restart (pet) and service strobes per timer
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mci_wdt
  import mci_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire wdt_cfg_t    cfg_i,
  input  wire wdt_ctrl_t   ctrl_i,
  output wdt_status_t      status_o
);

  // Index 0 is timer 1, index 1 is timer 2
  localparam int NumTimers = 2;

  wdt_cnt_t               cnt_q [NumTimers];
  wdt_cnt_t               period [NumTimers];
  logic [NumTimers-1:0]   timeout_q;
  logic [NumTimers-1:0]   restart;
  logic [NumTimers-1:0]   service;
  logic [NumTimers-1:0]   active;
  logic [NumTimers-1:0]   expire;
  logic                   t2_run;

  ////////////////////
  // Per-timer controls
  ////////////////////

  always_comb begin
    restart   = {ctrl_i.t2_restart, ctrl_i.t1_restart};
    service   = {ctrl_i.t2_service, ctrl_i.t1_service};
    period[0] = cfg_i.t1_period;
    period[1] = cfg_i.t2_period;
  end

  // Mode select for timer 2
  // In cascade mode the pending timer 1 timeout is its enable
  assign t2_run = cfg_i.t2_en ? 1'b1 : timeout_q[0];

  // A timer stops counting once its timeout is pending
  always_comb begin
    active[0] = cfg_i.t1_en & ~timeout_q[0];
    active[1] = t2_run & ~timeout_q[1];
  end

  // Count reached the period while running
  always_comb begin
    for (int i = 0; i < NumTimers; i++) begin
      expire[i] = active[i] & (cnt_q[i] == period[i]);
    end
  end

  ////////////////////
  // Counters and flags
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NumTimers; i++) begin
        cnt_q[i] <= '0;
      end
      timeout_q <= '0;
    end else begin
      for (int i = 0; i < NumTimers; i++) begin
        // Pet or service both restart the count
        if (restart[i] | service[i]) begin
          cnt_q[i] <= '0;
        end else if (active[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end

        // Service has priority over a new expiry
        if (service[i]) begin
          timeout_q[i] <= 1'b0;
        end else if (expire[i]) begin
          timeout_q[i] <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Status
  ////////////////////

  always_comb begin
    status_o.t1_timeout = timeout_q[0];
    status_o.t2_timeout = timeout_q[1];
  end

endmodule

`default_nettype wire

// File: verilog/mci_error_regs.sv
////////////////////
// Sticky error registers
//   Fatal and non-fatal hardware error bits with W1C clears
//   NMI bit raised by a timer 2 timeout
//   Firmware fatal and non-fatal error codes
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mci_error_regs
  import mci_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  // Hardware error pulses
  input  wire hw_err_fatal_t     hw_fatal_i,
  input  wire hw_err_non_fatal_t hw_non_fatal_i,
  input  wire wdt_status_t       wdt_status_i,
  // Write-one-to-clear strobes
  input  wire hw_err_fatal_t     fatal_clr_i,
  input  wire hw_err_non_fatal_t non_fatal_clr_i,
  // Firmware error writes
  input  wire logic              fw_fatal_wr_i,
  input  wire fw_err_t           fw_fatal_code_i,
  input  wire logic              fw_non_fatal_wr_i,
  input  wire fw_err_t           fw_non_fatal_code_i,
  output hw_err_fatal_t          fatal_o,
  output hw_err_non_fatal_t      non_fatal_o,
  output fw_err_t                fw_fatal_o,
  output fw_err_t                fw_non_fatal_o
);

  hw_err_fatal_t     fatal_q;
  hw_err_non_fatal_t non_fatal_q;
  hw_err_fatal_t     fatal_set;
  fw_err_t           fw_fatal_q;
  fw_err_t           fw_non_fatal_q;
  logic              t2_timeout_q;
  logic              t2_rise;

  ////////////////////
  // NMI source
  ////////////////////

  // Only the first cycle of a timer 2 timeout counts
  assign t2_rise = wdt_status_i.t2_timeout & ~t2_timeout_q;

  always_comb begin
    fatal_set     = hw_fatal_i;
    fatal_set.nmi = hw_fatal_i.nmi | t2_rise;
  end

  ////////////////////
  // Sticky bits
  ////////////////////

  // Set wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      t2_timeout_q <= 1'b0;
      fatal_q      <= '0;
      non_fatal_q  <= '0;
    end else begin
      t2_timeout_q <= wdt_status_i.t2_timeout;
      fatal_q      <= (fatal_q & ~fatal_clr_i) | fatal_set;
      non_fatal_q  <= (non_fatal_q & ~non_fatal_clr_i) | hw_non_fatal_i;
    end
  end

  // Firmware codes, a write of zero clears
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fw_fatal_q     <= '0;
      fw_non_fatal_q <= '0;
    end else begin
      if (fw_fatal_wr_i) begin
        fw_fatal_q <= fw_fatal_code_i;
      end
      if (fw_non_fatal_wr_i) begin
        fw_non_fatal_q <= fw_non_fatal_code_i;
      end
    end
  end

  assign fatal_o        = fatal_q;
  assign non_fatal_o    = non_fatal_q;
  assign fw_fatal_o     = fw_fatal_q;
  assign fw_non_fatal_o = fw_non_fatal_q;

endmodule

`default_nettype wire

// File: verilog/mci_error_agg.sv
////////////////////
// Error aggregation
//   Masks hardware, firmware and external aggregate sources
//   Registered all-error-fatal and all-error-non-fatal outputs
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mci_error_agg
  import mci_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire hw_err_fatal_t     fatal_i,
  input  wire hw_err_non_fatal_t non_fatal_i,
  input  wire fw_err_t           fw_fatal_i,
  input  wire fw_err_t           fw_non_fatal_i,
  input  wire agg_err_t          agg_fatal_i,
  input  wire agg_err_t          agg_non_fatal_i,
  // A mask bit of 1 suppresses its source
  input  wire hw_err_fatal_t     fatal_mask_i,
  input  wire hw_err_non_fatal_t non_fatal_mask_i,
  input  wire fw_err_t           fw_fatal_mask_i,
  input  wire fw_err_t           fw_non_fatal_mask_i,
  input  wire agg_err_t          agg_fatal_mask_i,
  input  wire agg_err_t          agg_non_fatal_mask_i,
  output logic                   all_error_fatal_o,
  output logic                   all_error_non_fatal_o
);

  agg_err_t agg_fatal_q;
  agg_err_t agg_non_fatal_q;
  logic     hw_fatal_hit;
  logic     fw_fatal_hit;
  logic     agg_fatal_hit;
  logic     hw_non_fatal_hit;
  logic     fw_non_fatal_hit;
  logic     agg_non_fatal_hit;

  ////////////////////
  // Masking
  ////////////////////

  always_comb begin
    hw_fatal_hit      = |(fatal_i & ~fatal_mask_i);
    fw_fatal_hit      = |(fw_fatal_i & ~fw_fatal_mask_i);
    agg_fatal_hit     = |(agg_fatal_q & ~agg_fatal_mask_i);
    hw_non_fatal_hit  = |(non_fatal_i & ~non_fatal_mask_i);
    fw_non_fatal_hit  = |(fw_non_fatal_i & ~fw_non_fatal_mask_i);
    agg_non_fatal_hit = |(agg_non_fatal_q & ~agg_non_fatal_mask_i);
  end

  ////////////////////
  // Registers
  ////////////////////

  // External inputs take one register stage before the mask
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      agg_fatal_q           <= '0;
      agg_non_fatal_q       <= '0;
      all_error_fatal_o     <= 1'b0;
      all_error_non_fatal_o <= 1'b0;
    end else begin
      agg_fatal_q           <= agg_fatal_i;
      agg_non_fatal_q       <= agg_non_fatal_i;
      all_error_fatal_o     <= hw_fatal_hit | fw_fatal_hit | agg_fatal_hit;
      all_error_non_fatal_o <= hw_non_fatal_hit | fw_non_fatal_hit | agg_non_fatal_hit;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mci_top.sv
////////////////////
// Management controller error and watchdog top
//   Watchdog, sticky error registers, aggregation
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mci_top
  import mci_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  // Watchdog
  input  wire wdt_cfg_t          wdt_cfg_i,
  input  wire wdt_ctrl_t         wdt_ctrl_i,
  output wdt_status_t            wdt_status_o,
  // Hardware error pulses
  input  wire logic              sram_ecc_unc_i,
  input  wire logic              dmi_axi_collision_i,
  input  wire logic              mbox0_ecc_unc_i,
  input  wire logic              mbox1_ecc_unc_i,
  input  wire hw_err_fatal_t     fatal_clr_i,
  input  wire hw_err_non_fatal_t non_fatal_clr_i,
  // Firmware errors
  input  wire logic              fw_fatal_wr_i,
  input  wire fw_err_t           fw_fatal_code_i,
  input  wire logic              fw_non_fatal_wr_i,
  input  wire fw_err_t           fw_non_fatal_code_i,
  // External aggregate sources and masks
  input  wire agg_err_t          agg_fatal_i,
  input  wire agg_err_t          agg_non_fatal_i,
  input  wire hw_err_fatal_t     fatal_mask_i,
  input  wire hw_err_non_fatal_t non_fatal_mask_i,
  input  wire fw_err_t           fw_fatal_mask_i,
  input  wire fw_err_t           fw_non_fatal_mask_i,
  input  wire agg_err_t          agg_fatal_mask_i,
  input  wire agg_err_t          agg_non_fatal_mask_i,
  output hw_err_fatal_t          hw_err_fatal_o,
  output hw_err_non_fatal_t      hw_err_non_fatal_o,
  output logic                   all_error_fatal_o,
  output logic                   all_error_non_fatal_o
);

  hw_err_fatal_t     hw_fatal;
  hw_err_non_fatal_t hw_non_fatal;
  fw_err_t           fw_fatal;
  fw_err_t           fw_non_fatal;

  // NMI comes only from the watchdog
  assign hw_fatal     = '{nmi: 1'b0, sram_ecc_unc: sram_ecc_unc_i,
                          dmi_axi_collision: dmi_axi_collision_i};
  assign hw_non_fatal = '{mbox0_ecc_unc: mbox0_ecc_unc_i, mbox1_ecc_unc: mbox1_ecc_unc_i};

  mci_wdt u_wdt (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .cfg_i    (wdt_cfg_i),
    .ctrl_i   (wdt_ctrl_i),
    .status_o (wdt_status_o)
  );

  mci_error_regs u_error_regs (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .hw_fatal_i          (hw_fatal),
    .hw_non_fatal_i      (hw_non_fatal),
    .wdt_status_i        (wdt_status_o),
    .fatal_clr_i         (fatal_clr_i),
    .non_fatal_clr_i     (non_fatal_clr_i),
    .fw_fatal_wr_i       (fw_fatal_wr_i),
    .fw_fatal_code_i     (fw_fatal_code_i),
    .fw_non_fatal_wr_i   (fw_non_fatal_wr_i),
    .fw_non_fatal_code_i (fw_non_fatal_code_i),
    .fatal_o             (hw_err_fatal_o),
    .non_fatal_o         (hw_err_non_fatal_o),
    .fw_fatal_o          (fw_fatal),
    .fw_non_fatal_o      (fw_non_fatal)
  );

  mci_error_agg u_error_agg (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .fatal_i               (hw_err_fatal_o),
    .non_fatal_i           (hw_err_non_fatal_o),
    .fw_fatal_i            (fw_fatal),
    .fw_non_fatal_i        (fw_non_fatal),
    .agg_fatal_i           (agg_fatal_i),
    .agg_non_fatal_i       (agg_non_fatal_i),
    .fatal_mask_i          (fatal_mask_i),
    .non_fatal_mask_i      (non_fatal_mask_i),
    .fw_fatal_mask_i       (fw_fatal_mask_i),
    .fw_non_fatal_mask_i   (fw_non_fatal_mask_i),
    .agg_fatal_mask_i      (agg_fatal_mask_i),
    .agg_non_fatal_mask_i  (agg_non_fatal_mask_i),
    .all_error_fatal_o     (all_error_fatal_o),
    .all_error_non_fatal_o (all_error_non_fatal_o)
  );

endmodule

`default_nettype wire

// File: dv/mci_top_checks.sv
////////////////////
// Checker for the MCI error block
//   Reference watchdog, sticky register and aggregation model
//   Concurrent assertions on the top-level outputs
////////////////////

`timescale 1ns/1ps
`default_nettype none

module mci_top_checks
  import mci_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire wdt_cfg_t          wdt_cfg_i,
  input  wire wdt_ctrl_t         wdt_ctrl_i,
  input  wire wdt_status_t       wdt_status_o,
  input  wire logic              sram_ecc_unc_i,
  input  wire logic              dmi_axi_collision_i,
  input  wire logic              mbox0_ecc_unc_i,
  input  wire logic              mbox1_ecc_unc_i,
  input  wire hw_err_fatal_t     fatal_clr_i,
  input  wire hw_err_non_fatal_t non_fatal_clr_i,
  input  wire logic              fw_fatal_wr_i,
  input  wire fw_err_t           fw_fatal_code_i,
  input  wire logic              fw_non_fatal_wr_i,
  input  wire fw_err_t           fw_non_fatal_code_i,
  input  wire agg_err_t          agg_fatal_i,
  input  wire agg_err_t          agg_non_fatal_i,
  input  wire hw_err_fatal_t     fatal_mask_i,
  input  wire hw_err_non_fatal_t non_fatal_mask_i,
  input  wire fw_err_t           fw_fatal_mask_i,
  input  wire fw_err_t           fw_non_fatal_mask_i,
  input  wire agg_err_t          agg_fatal_mask_i,
  input  wire agg_err_t          agg_non_fatal_mask_i,
  input  wire hw_err_fatal_t     hw_err_fatal_o,
  input  wire hw_err_non_fatal_t hw_err_non_fatal_o,
  input  wire logic              all_error_fatal_o,
  input  wire logic              all_error_non_fatal_o,
  output logic                   fail_o
);

  wdt_cnt_t          ref_cnt1;
  wdt_cnt_t          ref_cnt2;
  logic              ref_to1;
  logic              ref_to2;
  logic              ref_to2_d;
  logic              run1;
  logic              run2;
  wdt_status_t       ref_status;
  hw_err_fatal_t     ref_fatal;
  hw_err_non_fatal_t ref_non_fatal;
  fw_err_t           ref_fw_fatal;
  fw_err_t           ref_fw_non_fatal;
  agg_err_t          ref_agg_fatal;
  agg_err_t          ref_agg_non_fatal;
  logic              ref_all_fatal;
  logic              ref_all_non_fatal;

  initial fail_o = 1'b0;

  task automatic flag_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    fail_o = 1'b1;
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Timer 2 runs in independent mode, or while timer 1 has expired
  assign run1       = wdt_cfg_i.t1_en && !ref_to1;
  assign run2       = (wdt_cfg_i.t2_en || ref_to1) && !ref_to2;
  assign ref_status = '{t1_timeout: ref_to1, t2_timeout: ref_to2};

  always @(posedge clk_i) begin
    if (rst_i) begin
      ref_cnt1 <= '0;
      ref_cnt2 <= '0;
      ref_to1  <= 1'b0;
      ref_to2  <= 1'b0;
    end else begin
      ref_cnt1 <= (wdt_ctrl_i.t1_restart || wdt_ctrl_i.t1_service) ? '0 :
                  run1 ? ref_cnt1 + 1'b1 : ref_cnt1;
      ref_cnt2 <= (wdt_ctrl_i.t2_restart || wdt_ctrl_i.t2_service) ? '0 :
                  run2 ? ref_cnt2 + 1'b1 : ref_cnt2;
      ref_to1  <= !wdt_ctrl_i.t1_service &&
                  (ref_to1 || (run1 && ref_cnt1 == wdt_cfg_i.t1_period));
      ref_to2  <= !wdt_ctrl_i.t2_service &&
                  (ref_to2 || (run2 && ref_cnt2 == wdt_cfg_i.t2_period));
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      ref_to2_d         <= 1'b0;
      ref_fatal         <= '0;
      ref_non_fatal     <= '0;
      ref_fw_fatal      <= '0;
      ref_fw_non_fatal  <= '0;
      ref_agg_fatal     <= '0;
      ref_agg_non_fatal <= '0;
      ref_all_fatal     <= 1'b0;
      ref_all_non_fatal <= 1'b0;
    end else begin
      ref_to2_d <= ref_to2;
      ref_fatal.nmi <= (ref_to2 && !ref_to2_d) || (ref_fatal.nmi && !fatal_clr_i.nmi);
      ref_fatal.sram_ecc_unc <= sram_ecc_unc_i ||
                                (ref_fatal.sram_ecc_unc && !fatal_clr_i.sram_ecc_unc);
      ref_fatal.dmi_axi_collision <= dmi_axi_collision_i ||
        (ref_fatal.dmi_axi_collision && !fatal_clr_i.dmi_axi_collision);
      ref_non_fatal.mbox0_ecc_unc <= mbox0_ecc_unc_i ||
        (ref_non_fatal.mbox0_ecc_unc && !non_fatal_clr_i.mbox0_ecc_unc);
      ref_non_fatal.mbox1_ecc_unc <= mbox1_ecc_unc_i ||
        (ref_non_fatal.mbox1_ecc_unc && !non_fatal_clr_i.mbox1_ecc_unc);
      if (fw_fatal_wr_i) ref_fw_fatal <= fw_fatal_code_i;
      if (fw_non_fatal_wr_i) ref_fw_non_fatal <= fw_non_fatal_code_i;
      ref_agg_fatal     <= agg_fatal_i;
      ref_agg_non_fatal <= agg_non_fatal_i;
      ref_all_fatal     <= (ref_fatal & ~fatal_mask_i) != '0 ||
                           (ref_fw_fatal & ~fw_fatal_mask_i) != '0 ||
                           (ref_agg_fatal & ~agg_fatal_mask_i) != '0;
      ref_all_non_fatal <= (ref_non_fatal & ~non_fatal_mask_i) != '0 ||
                           (ref_fw_non_fatal & ~fw_non_fatal_mask_i) != '0 ||
                           (ref_agg_non_fatal & ~agg_non_fatal_mask_i) != '0;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  reset_clean: assert property (@(posedge clk_i) rst_i |=> (!all_error_fatal_o &&
      !all_error_non_fatal_o && wdt_status_o == '0 && hw_err_fatal_o == '0 &&
      hw_err_non_fatal_o == '0))
    else flag_mismatch("outputs not low after reset");
  status_match: assert property (@(posedge clk_i) disable iff (rst_i)
      wdt_status_o == ref_status)
    else flag_mismatch("watchdog status differs from reference");
  fatal_match: assert property (@(posedge clk_i) disable iff (rst_i)
      hw_err_fatal_o == ref_fatal)
    else flag_mismatch("sticky fatal bits differ from reference");
  non_fatal_match: assert property (@(posedge clk_i) disable iff (rst_i)
      hw_err_non_fatal_o == ref_non_fatal)
    else flag_mismatch("sticky non-fatal bits differ from reference");
  all_fatal_match: assert property (@(posedge clk_i) disable iff (rst_i)
      all_error_fatal_o == ref_all_fatal)
    else flag_mismatch("all_error_fatal_o differs from reference");
  all_non_fatal_match: assert property (@(posedge clk_i) disable iff (rst_i)
      all_error_non_fatal_o == ref_all_non_fatal)
    else flag_mismatch("all_error_non_fatal_o differs from reference");

endmodule

`default_nettype wire

// File: dv/mci_top_tb.sv
////////////////////
// Testbench for the MCI error and watchdog block
//   Clock, reset and seeded stimulus
//   Watchdog process and final report
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mci_defines.svh"

module mci_top_tb
  import mci_pkg::*;
;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 10;
  // Upper bounds of each test in cycles
  localparam int cascade_cycles = 200;
  localparam int indep_cycles   = 400;
  localparam int hw_err_cycles  = 300;
  localparam int mask_cycles    = 600;
  localparam int margin_cycles  = 500;
  localparam int timeout_ns = (reset_cycles + cascade_cycles + indep_cycles + hw_err_cycles +
                               mask_cycles + margin_cycles) * clk_period;

  logic clk_i = 1'b0;
  logic rst_i, sram_ecc_unc_i, dmi_axi_collision_i, mbox0_ecc_unc_i, mbox1_ecc_unc_i;
  logic fw_fatal_wr_i, fw_non_fatal_wr_i, all_error_fatal_o, all_error_non_fatal_o;
  logic check_fail;
  wdt_cfg_t wdt_cfg_i;
  wdt_ctrl_t wdt_ctrl_i;
  wdt_status_t wdt_status_o;
  hw_err_fatal_t fatal_clr_i, fatal_mask_i, hw_err_fatal_o;
  hw_err_non_fatal_t non_fatal_clr_i, non_fatal_mask_i, hw_err_non_fatal_o;
  fw_err_t fw_fatal_code_i, fw_non_fatal_code_i, fw_fatal_mask_i, fw_non_fatal_mask_i;
  agg_err_t agg_fatal_i, agg_non_fatal_i, agg_fatal_mask_i, agg_non_fatal_mask_i;
  wdt_cnt_t p1, p2;

  always #(clk_period / 2) clk_i = ~clk_i;

  mci_top uut (.*);
  mci_top_checks checks (.fail_o(check_fail), .*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic pulse_ctrl(input wdt_ctrl_t c);
    wdt_ctrl_i = c;
    step();
    wdt_ctrl_i = '0;
  endtask

  task automatic clear_all();
    fatal_clr_i     = '1;
    non_fatal_clr_i = '1;
    step();
    fatal_clr_i     = '0;
    non_fatal_clr_i = '0;
  endtask

  task automatic cascade_timeouts();
    p1 = wdt_cnt_t'(4 + $urandom % 8);
    p2 = wdt_cnt_t'(4 + $urandom % 8);
    wdt_cfg_i = '{t1_en: 1'b1, t2_en: 1'b0, t1_period: p1, t2_period: p2};
    pulse_ctrl('{t1_restart: 1'b1, t2_restart: 1'b1, default: 1'b0});
    while (!wdt_status_o.t1_timeout) step();
    while (!wdt_status_o.t2_timeout) step();
    repeat (3) step();
    pulse_ctrl('{t2_service: 1'b1, default: 1'b0});
    pulse_ctrl('{t1_service: 1'b1, default: 1'b0});
    wdt_cfg_i.t1_en = 1'b0;
    repeat (2) step();
    clear_all();
  endtask

  task automatic independent_pets();
    p1 = wdt_cnt_t'(5 + $urandom % 8);
    p2 = wdt_cnt_t'(5 + $urandom % 8);
    wdt_cfg_i = '{t1_en: 1'b1, t2_en: 1'b1, t1_period: p1, t2_period: p2};
    // Pets arrive before either period runs out
    repeat (20) begin
      pulse_ctrl('{t1_restart: 1'b1, t2_restart: 1'b1, default: 1'b0});
      repeat (((p1 < p2) ? p1 : p2) - 3) step();
    end
    while (!(wdt_status_o.t1_timeout && wdt_status_o.t2_timeout)) step();
    pulse_ctrl('{t1_service: 1'b1, t2_service: 1'b1, default: 1'b0});
    wdt_cfg_i.t1_en = 1'b0;
    wdt_cfg_i.t2_en = 1'b0;
    repeat (2) step();
    clear_all();
  endtask

  task automatic sticky_errors();
    repeat (hw_err_cycles) begin
      sram_ecc_unc_i      = ($urandom % 5) == 0;
      dmi_axi_collision_i = ($urandom % 5) == 0;
      mbox0_ecc_unc_i     = ($urandom % 5) == 0;
      mbox1_ecc_unc_i     = ($urandom % 5) == 0;
      fatal_clr_i         = hw_err_fatal_t'($urandom % 8);
      non_fatal_clr_i     = hw_err_non_fatal_t'($urandom % 4);
      step();
    end
    {sram_ecc_unc_i, dmi_axi_collision_i, mbox0_ecc_unc_i, mbox1_ecc_unc_i} = '0;
    clear_all();
  endtask

  task automatic masked_aggregation();
    for (int i = 0; i < mask_cycles; i++) begin
      if (i % 50 == 0) begin
        // Every fourth phase masks every source
        if ((i / 50) % 4 == 3) begin
          {fatal_mask_i, non_fatal_mask_i, fw_fatal_mask_i, fw_non_fatal_mask_i} = '1;
          {agg_fatal_mask_i, agg_non_fatal_mask_i} = '1;
        end else begin
          fatal_mask_i         = hw_err_fatal_t'($urandom % 8);
          non_fatal_mask_i     = hw_err_non_fatal_t'($urandom % 4);
          fw_fatal_mask_i      = $urandom;
          fw_non_fatal_mask_i  = $urandom;
          agg_fatal_mask_i     = agg_err_t'($urandom);
          agg_non_fatal_mask_i = agg_err_t'($urandom);
        end
      end
      fw_fatal_wr_i       = ($urandom % 6) == 0;
      fw_fatal_code_i     = ($urandom % 2 == 0) ? '0 : $urandom;
      fw_non_fatal_wr_i   = ($urandom % 6) == 0;
      fw_non_fatal_code_i = ($urandom % 2 == 0) ? '0 : $urandom;
      agg_fatal_i         = agg_err_t'($urandom & $urandom);
      agg_non_fatal_i     = agg_err_t'($urandom & $urandom);
      sram_ecc_unc_i      = ($urandom % 20) == 0;
      dmi_axi_collision_i = ($urandom % 20) == 0;
      mbox0_ecc_unc_i     = ($urandom % 20) == 0;
      mbox1_ecc_unc_i     = ($urandom % 20) == 0;
      fatal_clr_i         = hw_err_fatal_t'($urandom % 8);
      non_fatal_clr_i     = hw_err_non_fatal_t'($urandom % 4);
      step();
    end
    {fw_fatal_wr_i, fw_non_fatal_wr_i} = '0;
    {sram_ecc_unc_i, dmi_axi_collision_i, mbox0_ecc_unc_i, mbox1_ecc_unc_i} = '0;
    repeat (4) step();
  endtask

  always @(posedge check_fail) abort_run("Checker reported a failure");

  initial begin
    #(timeout_ns);
    abort_run("Simulation ran past its time limit");
  end

  initial begin
    void'($urandom(32'h5e1b));
    rst_i = 1'b1;
    wdt_cfg_i = '0;
    wdt_ctrl_i = '0;
    {sram_ecc_unc_i, dmi_axi_collision_i, mbox0_ecc_unc_i, mbox1_ecc_unc_i} = '0;
    {fatal_clr_i, non_fatal_clr_i, fatal_mask_i, non_fatal_mask_i} = '0;
    {fw_fatal_wr_i, fw_non_fatal_wr_i, fw_fatal_code_i, fw_non_fatal_code_i} = '0;
    {fw_fatal_mask_i, fw_non_fatal_mask_i} = '0;
    {agg_fatal_i, agg_non_fatal_i, agg_fatal_mask_i, agg_non_fatal_mask_i} = '0;
    repeat (reset_cycles) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    repeat (3) step();
    cascade_timeouts();
    independent_pets();
    sticky_errors();
    masked_aggregation();
    if (check_fail) begin
      abort_run("Checker failure seen at end of run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: mci_top.f
+incdir+verilog
verilog/mci_pkg.sv
verilog/mci_wdt.sv
verilog/mci_error_regs.sv
verilog/mci_error_agg.sv
verilog/mci_top.sv
dv/mci_top_checks.sv
dv/mci_top_tb.sv

// File: Makefile
# Verilator build and run for the MCI error and watchdog block

VERILATOR ?= verilator
TOP       ?= mci_top_tb
FILELIST  ?= mci_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then \
	  echo "Simulation did not complete"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
